//--- fpu_params.svh
`ifndef FPU_PARAMS_SVH
`define FPU_PARAMS_SVH

// binary32 field layout
`define FPU_MAN_W 23
`define FPU_EXP_BIAS 127

// internal signed exponent, wide enough for the raw product exponent
`define FPU_EXP_W 10

`define FPU_QNAN 32'h7fc00000

// stages between an accepted input and its result
`define FPU_LATENCY 3

`endif

//--- fpu_pkg.sv
package fpu_pkg;

	// rounding modes, same encoding as the RISC-V frm field
	typedef enum logic [2:0] {
		FPU_RM_RNE = 3'd0,
		FPU_RM_RTZ = 3'd1,
		FPU_RM_RDN = 3'd2,
		FPU_RM_RUP = 3'd3,
		FPU_RM_RMM = 3'd4
	} fpu_rm_e;

	// operand class once subnormals are flushed
	typedef enum logic [1:0] {
		CLS_ZERO,
		CLS_NORM,
		CLS_INF,
		CLS_NAN
	} fpu_class_e;

endpackage

//--- rshifter.sv
`timescale 1ns/1ps

module rshifter #(
	parameter int width = 25,
	parameter int sel_w = 5
) (
	input	logic	[width-1:0]	in,
	input	logic	[sel_w-1:0]	sel,
	input	logic				sgn,
	output	logic	[width-1:0]	out,
	output	logic				sticky_bit
);

	// ones on every bit position that falls off the right end
	logic	[width-1:0]	lost_mask;

	assign lost_mask = ~({width{1'b1}} << sel);

	always_comb begin
		if (sgn)
			out = $signed(in) >>> sel;
		else
			out = in >> sel;
	end

	assign sticky_bit = |(in & lost_mask);

endmodule

//--- rounding_logic.sv
`timescale 1ns/1ps

module rounding_logic import fpu_pkg::*; #(
	parameter int width = 23
) (
	input	fpu_rm_e			rm,
	input	logic				sticky_bit,
	input	logic				round_bit,
	input	logic				sgn,
	input	logic	[width-1:0]	in,
	output	logic	[width-1:0]	out,
	output	logic				carry,
	output	logic				inexact
);

	logic	inc;
	logic	discarded;

	assign discarded = round_bit | sticky_bit;

	always_comb begin
		case (rm)
			// tie goes to even
			FPU_RM_RNE: inc = round_bit & (sticky_bit | in[0]);
			FPU_RM_RTZ: inc = 1'b0;
			FPU_RM_RDN: inc = sgn & discarded;
			FPU_RM_RUP: inc = !sgn & discarded;
			// tie goes away from zero
			FPU_RM_RMM: inc = round_bit;
			default: inc = 1'b0;
		endcase
	end

	// carry out means the mantissa wrapped to the next binade
	assign {carry, out} = {1'b0, in} + {{width{1'b0}}, inc};

	assign inexact = discarded;

endmodule

//--- fpu_unpack.sv
`timescale 1ns/1ps
`include "fpu_params.svh"

module fpu_unpack import fpu_pkg::*; (
	input	logic				clk,
	input	logic				reset,
	input	logic				valid_in,
	output	logic				ready_out,
	output	logic				valid_out,
	input	logic				ready_in,
	input	logic	[31:0]		a,
	input	logic	[31:0]		b,
	input	fpu_rm_e			rm,
	output	logic	[`FPU_MAN_W:0]	man_a,
	output	logic	[`FPU_MAN_W:0]	man_b,
	output	logic	[7:0]		exp_a,
	output	logic	[7:0]		exp_b,
	output	logic				sgn,
	output	fpu_rm_e			rm_out,
	output	logic				skip_round,
	output	logic	[31:0]		spec_out,
	output	logic				IV
);

	fpu_class_e		cls_a;
	fpu_class_e		cls_b;
	logic			snan_a;
	logic			snan_b;
	logic			sgn_c;
	logic			skip_c;
	logic			iv_c;
	logic	[31:0]	spec_c;

	// zero exponent counts as zero, so subnormal inputs are flushed here
	function automatic fpu_class_e classify(input logic [31:0] x);
		fpu_class_e cls;
		if (x[30:23] == 8'h00)
			cls = CLS_ZERO;
		else if (x[30:23] != 8'hff)
			cls = CLS_NORM;
		else if (x[22:0] == '0)
			cls = CLS_INF;
		else
			cls = CLS_NAN;
		return cls;
	endfunction

	assign ready_out = ready_in;

	assign cls_a = classify(a);
	assign cls_b = classify(b);
	// quiet bit clear means signaling
	assign snan_a = (cls_a == CLS_NAN) && !a[22];
	assign snan_b = (cls_b == CLS_NAN) && !b[22];
	assign sgn_c = a[31] ^ b[31];

	always_comb begin
		skip_c = 1'b1;
		iv_c = 1'b0;
		spec_c = {sgn_c, 31'h0};
		if (cls_a == CLS_NAN || cls_b == CLS_NAN) begin
			spec_c = `FPU_QNAN;
			iv_c = snan_a | snan_b;
		end else if ((cls_a == CLS_INF && cls_b == CLS_ZERO) ||
				(cls_a == CLS_ZERO && cls_b == CLS_INF)) begin
			// inf * 0 is invalid
			spec_c = `FPU_QNAN;
			iv_c = 1'b1;
		end else if (cls_a == CLS_INF || cls_b == CLS_INF) begin
			spec_c = {sgn_c, 8'hff, 23'h0};
		end else if (cls_a == CLS_ZERO || cls_b == CLS_ZERO) begin
			spec_c = {sgn_c, 31'h0};
		end else begin
			skip_c = 1'b0;
		end
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			valid_out <= 1'b0;
			skip_round <= 1'b0;
			IV <= 1'b0;
		end else if (valid_in && ready_out) begin
			valid_out <= 1'b1;
			skip_round <= skip_c;
			IV <= iv_c;
		end else if (valid_out && ready_in) begin
			valid_out <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_in && ready_out) begin
			man_a <= {1'b1, a[22:0]};
			man_b <= {1'b1, b[22:0]};
			exp_a <= a[30:23];
			exp_b <= b[30:23];
			sgn <= sgn_c;
			rm_out <= rm;
			spec_out <= spec_c;
		end
	end

endmodule

//--- fpu_mul_core.sv
`timescale 1ns/1ps
`include "fpu_params.svh"

module fpu_mul_core import fpu_pkg::*; (
	input	logic					clk,
	input	logic					reset,
	input	logic					valid_in,
	output	logic					ready_out,
	output	logic					valid_out,
	input	logic					ready_in,
	input	logic	[`FPU_MAN_W:0]		man_a,
	input	logic	[`FPU_MAN_W:0]		man_b,
	input	logic	[7:0]			exp_a,
	input	logic	[7:0]			exp_b,
	input	logic					sgn,
	input	fpu_rm_e				rm,
	input	logic					skip_round,
	input	logic	[31:0]			spec_in,
	input	logic					IV_in,
	output	logic	[`FPU_MAN_W:0]		man_out,
	output	logic	[`FPU_EXP_W-1:0]	exp_out,
	output	logic					sgn_out,
	output	logic					round_bit,
	output	logic					sticky_bit,
	output	logic					skip_round_out,
	output	logic					IV_out,
	output	fpu_rm_e				rm_out
);

	localparam logic [`FPU_EXP_W-1:0] bias_x2 = 2 * `FPU_EXP_BIAS;

	logic	[2*`FPU_MAN_W+1:0]	prod;
	logic						norm;
	logic	[`FPU_MAN_W:0]		man_c;
	logic	[`FPU_EXP_W-1:0]	exp_c;
	logic						sgn_c;
	logic						round_c;
	logic						sticky_c;

	assign ready_out = ready_in;

	// 1.x * 1.x lies in [1, 4)
	assign prod = man_a * man_b;
	assign norm = prod[2*`FPU_MAN_W+1];

	always_comb begin
		exp_c = {2'b00, exp_a} + {2'b00, exp_b} + {9'd0, norm} - bias_x2;
		sgn_c = sgn;
		if (norm) begin
			man_c = prod[47:24];
			round_c = prod[23];
			sticky_c = |prod[22:0];
		end else begin
			man_c = prod[46:23];
			round_c = prod[22];
			sticky_c = |prod[21:0];
		end
		// special result rides on the mantissa and exponent lanes
		if (skip_round) begin
			man_c = {1'b0, spec_in[22:0]};
			exp_c = {2'b00, spec_in[30:23]};
			sgn_c = spec_in[31];
			round_c = 1'b0;
			sticky_c = 1'b0;
		end
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			valid_out <= 1'b0;
			skip_round_out <= 1'b0;
			IV_out <= 1'b0;
		end else if (valid_in && ready_out) begin
			valid_out <= 1'b1;
			skip_round_out <= skip_round;
			IV_out <= IV_in;
		end else if (valid_out && ready_in) begin
			valid_out <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_in && ready_out) begin
			man_out <= man_c;
			exp_out <= exp_c;
			sgn_out <= sgn_c;
			round_bit <= round_c;
			sticky_bit <= sticky_c;
			rm_out <= rm;
		end
	end

endmodule

//--- post_processor.sv
`timescale 1ns/1ps
`include "fpu_params.svh"

module post_processor import fpu_pkg::*; (
	input	logic					clk,
	input	logic					reset,
	input	logic					valid_in,
	output	logic					ready_out,
	output	logic					valid_out,
	input	logic					ready_in,
	input	fpu_rm_e				rm,
	input	logic	[`FPU_MAN_W:0]		man_in,
	input	logic	[`FPU_EXP_W-1:0]	exp_in,
	input	logic					sgn_in,
	input	logic					round_bit,
	input	logic					sticky_bit,
	input	logic					skip_round,
	input	logic					IV_in,
	output	logic	[31:0]			float_out,
	output	logic					IV,
	output	logic					OF,
	output	logic					UF,
	output	logic					IE
);

	localparam logic [`FPU_EXP_W-1:0] bias = `FPU_EXP_BIAS;

	fpu_rm_e					reg_rm;
	logic	[`FPU_MAN_W-1:0]	reg_man;
	logic	[`FPU_EXP_W-1:0]	reg_exp;
	logic						reg_sgn;
	logic						reg_round_bit;
	logic						reg_sticky_bit;
	logic						reg_skip_round;
	logic						reg_equal;
	logic						reg_less;

	logic	[`FPU_EXP_W-1:0]	exp_sum;
	logic	[`FPU_EXP_W-1:0]	exp_biased;
	logic						equal;
	logic						less;
	logic	[`FPU_EXP_W-1:0]	offset;
	logic	[4:0]				shift_sel;

	logic	[`FPU_MAN_W+1:0]	shifter_out;
	logic						shift_sticky;

	logic	[`FPU_MAN_W-1:0]	man_rounded;
	logic	[`FPU_EXP_W-1:0]	exp_rounded;
	logic						inc_exp;
	logic						inexact;
	logic						max_finite;

	assign ready_out = ready_in;

	// rebias, then find out whether the result lands in the subnormal range
	assign exp_sum = exp_in + bias;
	assign equal = (exp_sum == '0);
	assign less = exp_sum[`FPU_EXP_W-1];

	// biased exponent <= 0 needs 1 - e extra shifts, result exponent becomes 0
	assign offset = (equal || less) ? 10'd1 - exp_sum : '0;
	assign exp_biased = (equal || less) ? '0 : exp_sum;
	assign shift_sel = |offset[9:5] ? 5'h1f : offset[4:0];

	// round bit travels along as the lsb so it shifts with the mantissa
	rshifter #(
		.width(`FPU_MAN_W + 2),
		.sel_w(5)
	) u_rshifter (
		.in({man_in, round_bit}),
		.sel(shift_sel),
		.sgn(1'b0),
		.out(shifter_out),
		.sticky_bit(shift_sticky)
	);

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			valid_out <= 1'b0;
			reg_rm <= FPU_RM_RNE;
			reg_man <= '0;
			reg_exp <= '0;
			reg_sgn <= 1'b0;
			reg_round_bit <= 1'b0;
			reg_sticky_bit <= 1'b0;
			reg_skip_round <= 1'b0;
			reg_equal <= 1'b0;
			reg_less <= 1'b0;
			IV <= 1'b0;
		end else if (valid_in && ready_out) begin
			valid_out <= 1'b1;
			reg_rm <= rm;
			reg_sgn <= sgn_in;
			reg_skip_round <= skip_round;
			if (skip_round) begin
				// already packed, just hold it
				reg_man <= man_in[`FPU_MAN_W-1:0];
				reg_exp <= exp_in;
				reg_round_bit <= 1'b0;
				reg_sticky_bit <= 1'b0;
				reg_equal <= 1'b0;
				reg_less <= 1'b0;
				IV <= IV_in;
			end else begin
				// hidden bit at shifter_out[24] is dropped
				reg_man <= shifter_out[`FPU_MAN_W:1];
				reg_exp <= exp_biased;
				reg_round_bit <= shifter_out[0];
				reg_sticky_bit <= sticky_bit | shift_sticky;
				reg_equal <= equal;
				reg_less <= less;
				IV <= 1'b0;
			end
		end else if (valid_out && ready_in) begin
			// idle output reads as all zero
			valid_out <= 1'b0;
			reg_rm <= FPU_RM_RNE;
			reg_man <= '0;
			reg_exp <= '0;
			reg_sgn <= 1'b0;
			reg_round_bit <= 1'b0;
			reg_sticky_bit <= 1'b0;
			reg_skip_round <= 1'b0;
			reg_equal <= 1'b0;
			reg_less <= 1'b0;
			IV <= 1'b0;
		end
	end

	rounding_logic #(
		.width(`FPU_MAN_W)
	) u_rounding_logic (
		.rm(reg_rm),
		.sticky_bit(reg_sticky_bit),
		.round_bit(reg_round_bit),
		.sgn(reg_sgn),
		.in(reg_man),
		.out(man_rounded),
		.carry(inc_exp),
		.inexact(inexact)
	);

	// modes that round toward zero for this sign clamp to max finite
	assign max_finite = (reg_rm == FPU_RM_RTZ) ||
		(reg_rm == FPU_RM_RDN && !reg_sgn) ||
		(reg_rm == FPU_RM_RUP && reg_sgn);

	always_comb begin
		exp_rounded = reg_exp + {9'd0, inc_exp};
		float_out = {reg_sgn, reg_exp[7:0], reg_man};
		OF = 1'b0;
		UF = 1'b0;
		IE = 1'b0;
		if (!reg_skip_round) begin
			if (exp_rounded >= 10'd255) begin
				OF = 1'b1;
				IE = 1'b1;
				if (max_finite)
					float_out = {reg_sgn, 31'h7f7fffff};
				else
					float_out = {reg_sgn, 31'h7f800000};
			end else begin
				IE = inexact;
				// a carry out of a subnormal at e == 0 reaches the normal range
				UF = inexact && (reg_less || (reg_equal && !inc_exp));
				float_out = {reg_sgn, exp_rounded[7:0], man_rounded};
			end
		end
	end

endmodule

//--- fpu_mul.sv
`timescale 1ns/1ps
`include "fpu_params.svh"

module fpu_mul import fpu_pkg::*; (
	input	logic			clk,
	input	logic			reset,
	input	logic			valid_in,
	output	logic			ready_out,
	output	logic			valid_out,
	input	logic			ready_in,
	input	logic	[31:0]	a,
	input	logic	[31:0]	b,
	input	fpu_rm_e		rm,
	output	logic	[31:0]	float_out,
	output	logic			IV,
	output	logic			OF,
	output	logic			UF,
	output	logic			IE
);

	// unpack to multiply
	logic						s1_valid;
	logic						s1_ready;
	logic	[`FPU_MAN_W:0]		s1_man_a;
	logic	[`FPU_MAN_W:0]		s1_man_b;
	logic	[7:0]				s1_exp_a;
	logic	[7:0]				s1_exp_b;
	logic						s1_sgn;
	fpu_rm_e					s1_rm;
	logic						s1_skip_round;
	logic	[31:0]				s1_spec;
	logic						s1_iv;

	// multiply to post processing
	logic						s2_valid;
	logic						s2_ready;
	logic	[`FPU_MAN_W:0]		s2_man;
	logic	[`FPU_EXP_W-1:0]	s2_exp;
	logic						s2_sgn;
	logic						s2_round_bit;
	logic						s2_sticky_bit;
	logic						s2_skip_round;
	logic						s2_iv;
	fpu_rm_e					s2_rm;

	fpu_unpack u_unpack (
		.clk(clk),
		.reset(reset),
		.valid_in(valid_in),
		.ready_out(ready_out),
		.valid_out(s1_valid),
		.ready_in(s1_ready),
		.a(a),
		.b(b),
		.rm(rm),
		.man_a(s1_man_a),
		.man_b(s1_man_b),
		.exp_a(s1_exp_a),
		.exp_b(s1_exp_b),
		.sgn(s1_sgn),
		.rm_out(s1_rm),
		.skip_round(s1_skip_round),
		.spec_out(s1_spec),
		.IV(s1_iv)
	);

	fpu_mul_core u_mul_core (
		.clk(clk),
		.reset(reset),
		.valid_in(s1_valid),
		.ready_out(s1_ready),
		.valid_out(s2_valid),
		.ready_in(s2_ready),
		.man_a(s1_man_a),
		.man_b(s1_man_b),
		.exp_a(s1_exp_a),
		.exp_b(s1_exp_b),
		.sgn(s1_sgn),
		.rm(s1_rm),
		.skip_round(s1_skip_round),
		.spec_in(s1_spec),
		.IV_in(s1_iv),
		.man_out(s2_man),
		.exp_out(s2_exp),
		.sgn_out(s2_sgn),
		.round_bit(s2_round_bit),
		.sticky_bit(s2_sticky_bit),
		.skip_round_out(s2_skip_round),
		.IV_out(s2_iv),
		.rm_out(s2_rm)
	);

	post_processor u_post_processor (
		.clk(clk),
		.reset(reset),
		.valid_in(s2_valid),
		.ready_out(s2_ready),
		.valid_out(valid_out),
		.ready_in(ready_in),
		.rm(s2_rm),
		.man_in(s2_man),
		.exp_in(s2_exp),
		.sgn_in(s2_sgn),
		.round_bit(s2_round_bit),
		.sticky_bit(s2_sticky_bit),
		.skip_round(s2_skip_round),
		.IV_in(s2_iv),
		.float_out(float_out),
		.IV(IV),
		.OF(OF),
		.UF(UF),
		.IE(IE)
	);

endmodule

//--- fpu_mul_asserts.sv
`timescale 1ns/1ps

module fpu_mul_asserts (
	input	logic			clk,
	input	logic			reset,
	input	logic			ready_in,
	input	logic			valid_out,
	input	logic	[31:0]	float_out,
	input	logic			IV,
	input	logic			OF,
	input	logic			UF,
	input	logic			IE
);

	// number of property failures so far
	int		fail_count = 0;

	// a stalled result stays put until it is taken
	assert property (@(posedge clk) disable iff (reset)
		(valid_out && !ready_in) |=> (valid_out && $stable(float_out)))
		else begin
			$error("result dropped or changed while stalled");
			fail_count++;
		end

	// reset leaves the output side idle
	assert property (@(posedge clk)
		reset |=> (!valid_out && float_out == 32'h0 && !IV && !OF && !UF && !IE))
		else begin
			$error("outputs not cleared by reset");
			fail_count++;
		end

	// overflow and underflow are always inexact
	assert property (@(posedge clk) disable iff (reset) OF |-> IE)
		else begin
			$error("OF raised without IE");
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (reset) UF |-> IE)
		else begin
			$error("UF raised without IE");
			fail_count++;
		end

endmodule

//--- fpu_mul_tb.sv
`timescale 1ns/1ps
`include "fpu_params.svh"

module fpu_mul_tb import fpu_pkg::*; ();

	localparam int n_rand = 40;
	localparam int n_total = 5 * n_rand + 12 + 33 + 45 + 100;
	localparam int timeout_cycles = (n_total + 20) * 4;

	logic			clk = 1'b0;
	logic			reset;
	logic			valid_in;
	logic			ready_in = 1'b1;
	logic	[31:0]	a;
	logic	[31:0]	b;
	fpu_rm_e		rm;
	logic			ready_out;
	logic			valid_out;
	logic	[31:0]	float_out;
	logic			IV;
	logic			OF;
	logic			UF;
	logic			IE;

	logic			bp_en = 1'b0;
	int				cycle = 0;
	int				errors = 0;
	int				n_sent = 0;
	int				n_checked = 0;
	int				err_mark;
	logic	[35:0]	want;
	logic	[35:0]	got;
	int				t0;

	// expected {IV, OF, UF, IE, result} and the operation that produced it
	logic	[35:0]	want_q[$];
	logic	[31:0]	opa_q[$];
	logic	[31:0]	opb_q[$];
	fpu_rm_e		rm_q[$];
	int				t0_q[$];

	fpu_mul u_dut (
		.clk(clk),
		.reset(reset),
		.valid_in(valid_in),
		.ready_out(ready_out),
		.valid_out(valid_out),
		.ready_in(ready_in),
		.a(a),
		.b(b),
		.rm(rm),
		.float_out(float_out),
		.IV(IV),
		.OF(OF),
		.UF(UF),
		.IE(IE)
	);

	bind fpu_mul fpu_mul_asserts u_asserts (
		.clk(clk),
		.reset(reset),
		.ready_in(ready_in),
		.valid_out(valid_out),
		.float_out(float_out),
		.IV(IV),
		.OF(OF),
		.UF(UF),
		.IE(IE)
	);

	always #50 clk = ~clk;

	function automatic fpu_class_e class_of(input logic [31:0] x);
		if (x[30:23] == 8'h00)
			return CLS_ZERO;
		if (x[30:23] != 8'hff)
			return CLS_NORM;
		if (x[22:0] == 23'h0)
			return CLS_INF;
		return CLS_NAN;
	endfunction

	// exact product, rounded once on the 24 bit or subnormal grid
	function automatic logic [35:0] ref_fmul(input logic [31:0] x, input logic [31:0] y,
			input fpu_rm_e m);
		fpu_class_e		cx;
		fpu_class_e		cy;
		logic			s;
		longint			e;
		longint			sh;
		logic	[63:0]	p;
		logic	[63:0]	keep;
		logic	[63:0]	rest;
		logic	[63:0]	half;
		logic	[63:0]	bits;
		logic			inc;
		logic			inexact;
		logic			to_zero;
		s = x[31] ^ y[31];
		cx = class_of(x);
		cy = class_of(y);
		if (cx == CLS_NAN || cy == CLS_NAN)
			return {(cx == CLS_NAN && !x[22]) || (cy == CLS_NAN && !y[22]), 3'b000, `FPU_QNAN};
		if ((cx == CLS_INF && cy == CLS_ZERO) || (cx == CLS_ZERO && cy == CLS_INF))
			return {4'b1000, `FPU_QNAN};
		if (cx == CLS_INF || cy == CLS_INF)
			return {4'b0000, s, 8'hff, 23'h0};
		if (cx == CLS_ZERO || cy == CLS_ZERO)
			return {4'b0000, s, 31'h0};
		p = {40'h0, 1'b1, x[22:0]} * {40'h0, 1'b1, y[22:0]};
		e = longint'(x[30:23]) + longint'(y[30:23]) - 127;
		if (p[47])
			e = e + 1;
		else
			p = p << 1;
		// below the normal range the grid gets coarser by one bit per step
		if (e >= 1)
			sh = 24;
		else
			sh = 25 - e;
		if (sh > 60)
			sh = 60;
		keep = p >> sh;
		rest = p & ((64'd1 << sh) - 64'd1);
		half = 64'd1 << (sh - 1);
		case (m)
			FPU_RM_RNE: inc = (rest > half) || (rest == half && keep[0]);
			FPU_RM_RDN: inc = s && (rest != 0);
			FPU_RM_RUP: inc = !s && (rest != 0);
			FPU_RM_RMM: inc = (rest >= half);
			default: inc = 1'b0;
		endcase
		inexact = (rest != 0);
		keep = keep + {63'd0, inc};
		// hidden bit and any carry land in the exponent field
		if (e >= 1)
			bits = e - 1;
		else
			bits = 64'd0;
		bits = (bits << 23) + keep;
		if (bits >= (64'd255 << 23)) begin
			to_zero = (m == FPU_RM_RTZ) || (m == FPU_RM_RDN && !s) || (m == FPU_RM_RUP && s);
			if (to_zero)
				return {4'b0101, s, 31'h7f7fffff};
			return {4'b0101, s, 31'h7f800000};
		end
		return {2'b00, inexact && (bits < (64'd1 << 23)), inexact, s, bits[30:0]};
	endfunction

	function automatic logic [31:0] with_exp(input int e);
		logic [31:0] r;
		r = $urandom;
		return {r[31], 8'(e), r[22:0]};
	endfunction

	function automatic logic [31:0] rand_normal(input int lo, input int hi);
		return with_exp(lo + $urandom % (hi - lo + 1));
	endfunction

	function automatic fpu_rm_e rand_rm();
		return fpu_rm_e'($urandom % 5);
	endfunction

	// called on a falling edge, returns on the falling edge after the accept
	task automatic send(input logic [31:0] x, input logic [31:0] y, input fpu_rm_e m);
		valid_in = 1'b1;
		a = x;
		b = y;
		rm = m;
		do
			@(posedge clk);
		while (!ready_out);
		@(negedge clk);
		valid_in = 1'b0;
	endtask

	task automatic drain();
		while (want_q.size() != 0)
			@(negedge clk);
	endtask

	task automatic report_test(input string name, input int n_ops);
		$display("%s: %0d operations, %0d errors", name, n_ops, errors - err_mark);
		err_mark = errors;
	endtask

	always @(negedge clk) begin
		if (bp_en)
			ready_in = ($urandom % 3 != 0);
		else
			ready_in = 1'b1;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= timeout_cycles) begin
			$display("timeout: pipeline stalled after %0d cycles", cycle);
			$display("Result: FAILED");
			$finish;
		end
	end

	always @(posedge clk) begin
		if (!reset) begin
			assert (ready_out == ready_in) else begin
				$display("mismatch at %0t: ready_out %b with ready_in %b", $time, ready_out,
					ready_in);
				errors++;
			end
			if (valid_out && ready_in) begin
				if (want_q.size() == 0) begin
					$display("result at %0t arrived with no operation pending", $time);
					errors++;
				end else begin
					want = want_q.pop_front();
					t0 = t0_q.pop_front();
					got = {IV, OF, UF, IE, float_out};
					n_checked++;
					assert (got == want) else begin
						$display("mismatch at %0t: a=%h b=%h rm=%0d got %h/%b, want %h/%b",
							$time, opa_q[0], opb_q[0], rm_q[0], got[31:0], got[35:32],
							want[31:0], want[35:32]);
						errors++;
					end
					void'(opa_q.pop_front());
					void'(opb_q.pop_front());
					void'(rm_q.pop_front());
					if (!bp_en) begin
						assert (cycle - t0 == `FPU_LATENCY) else begin
							$display("result at %0t took %0d cycles instead of %0d", $time,
								cycle - t0, `FPU_LATENCY);
							errors++;
						end
					end
				end
			end
			if (valid_in && ready_out) begin
				want_q.push_back(ref_fmul(a, b, rm));
				opa_q.push_back(a);
				opb_q.push_back(b);
				rm_q.push_back(rm);
				t0_q.push_back(cycle);
				n_sent++;
			end
		end
	end

	initial begin
		int ea;
		void'($urandom(67));
		reset = 1'b1;
		valid_in = 1'b0;
		a = 32'h0;
		b = 32'h0;
		rm = FPU_RM_RNE;
		err_mark = 0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		for (int k = 0; k < 5; k++)
			for (int i = 0; i < n_rand; i++)
				send(rand_normal(64, 190), rand_normal(64, 190), fpu_rm_e'(k));
		drain();
		report_test("random normal, all modes", 5 * n_rand);

		send(32'h7fc00000, 32'h3f800000, rand_rm());
		send(32'h3f800000, 32'h7f800001, rand_rm());
		send(32'h7fa00000, 32'hffc00000, rand_rm());
		send(32'h7fc00000, 32'h00000000, rand_rm());
		send(32'h7f800000, 32'h00000000, rand_rm());
		send(32'h80000000, 32'hff800000, rand_rm());
		send(32'h7f800000, 32'h40000000, rand_rm());
		send(32'hff800000, 32'hc0400000, rand_rm());
		send(32'h00000000, 32'h40a00000, rand_rm());
		send(32'h80000000, 32'h40e00000, rand_rm());
		// subnormal inputs count as zero
		send(32'h00400000, 32'h40000000, rand_rm());
		send(32'h807fffff, 32'h7f800000, rand_rm());
		drain();
		report_test("special operands", 12);

		for (int i = 0; i < 30; i++) begin
			ea = 200 + $urandom % 55;
			send(with_exp(ea), with_exp(379 + $urandom % 5 - ea), rand_rm());
		end
		send(32'h7f7fffff, 32'h3f800000, FPU_RM_RNE);
		send(32'h7f7fffff, 32'h3f800001, FPU_RM_RNE);
		send(32'hff7fffff, 32'h3f800001, FPU_RM_RUP);
		drain();
		report_test("overflow", 33);

		for (int i = 0; i < 40; i++) begin
			ea = 20 + $urandom % 40;
			send(with_exp(ea), with_exp(97 + $urandom % 32 - ea), rand_rm());
		end
		// exact tiny results, then a carry into the smallest normal
		send(32'h20000000, 32'h19000000, rand_rm());
		send(32'h20000000, 32'h19400000, rand_rm());
		send(32'h20000000, 32'h14800000, rand_rm());
		send(32'h3f7fffff, 32'h00800000, FPU_RM_RNE);
		send(32'h3f7fffff, 32'h00800000, FPU_RM_RTZ);
		drain();
		report_test("underflow and subnormal results", 45);

		bp_en = 1'b1;
		for (int i = 0; i < 100; i++)
			send(rand_normal(64, 190), rand_normal(64, 190), rand_rm());
		drain();
		bp_en = 1'b0;
		// a duplicated last result would show up within a few idle cycles
		repeat (2 * `FPU_LATENCY) @(negedge clk);
		report_test("back-pressure", 100);

		errors += u_dut.u_asserts.fail_count;
		$display("operations: %0d, checked: %0d, errors: %0d", n_sent, n_checked, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- fpu_mul.f
+incdir+.
fpu_pkg.sv
rshifter.sv
rounding_logic.sv
fpu_unpack.sv
fpu_mul_core.sv
post_processor.sv
fpu_mul.sv
fpu_mul_asserts.sv
fpu_mul_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator and run, status follows the testbench verdict
verilator --binary --timing --assert --top-module fpu_mul_tb -f fpu_mul.f -o fpu_mul_sim \
	&& ./obj_dir/fpu_mul_sim | tee /dev/stderr | grep -q "Result: PASSED" \
	&& echo "simulation run ok" \
	|| { echo "simulation run not ok"; exit 1; }
